// File: symbol_adjust_cfg.svh
`ifndef SYMBOL_ADJUST_CFG_SVH
`define SYMBOL_ADJUST_CFG_SVH

// Frame geometry.
`define WIDTH          16
`define SUBFRAME_WIDTH 8

// Datapath widths.
`define ENER_BITS      10
`define BRANCH_BITS    2
`define SYM_BITS       2

// Trellis error patterns.
`define NUM_PATTERNS   4
`define PATTERN_DEPTH  4

// Derived sizes.
`define WINDOW_LEN     (3 * `WIDTH - `SUBFRAME_WIDTH)
`define NUM_FLAGS      (2 * `NUM_PATTERNS + 1)

`endif

// File: symbol_adjust_pkg.sv
`include "symbol_adjust_cfg.svh"
`default_nettype none

package symbol_adjust_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Detector side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // 0 is no error, 2i+1 is pattern i, 2i+2 its negation.
    typedef logic [$clog2(`NUM_FLAGS)-1:0] flag_t;

    // Lower energy means a more likely error.
    typedef logic [`ENER_BITS-1:0] ener_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pattern and adjustment side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One tap of a loaded pattern.
    typedef logic signed [`BRANCH_BITS-1:0] branch_t;

    // Symbol adjustment whose sums wrap in two's complement.
    typedef logic signed [(2 ** `SYM_BITS - 1)-1:0] adjust_t;

    typedef logic [$clog2(`NUM_PATTERNS)-1:0] pattern_idx_t;

endpackage

`default_nettype wire

// File: flag_window_buffer.sv
`include "symbol_adjust_cfg.svh"
`default_nettype none

module flag_window_buffer (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           in_valid,
    input  wire symbol_adjust_pkg::flag_t in_flags [`WIDTH],
    input  wire symbol_adjust_pkg::ener_t in_ener [`WIDTH],
    output logic                          window_valid,
    output symbol_adjust_pkg::flag_t      window_flags [`WINDOW_LEN],
    output symbol_adjust_pkg::ener_t      window_ener [`WINDOW_LEN]
);
    import symbol_adjust_pkg::*;

    // Entries taken from the oldest frame.
    localparam int tail_len = `WIDTH - `SUBFRAME_WIDTH;

    // Index 0 is the previous frame, index 1 the one before.
    flag_t      hist_flags [2][`WIDTH];
    ener_t      hist_ener [2][`WIDTH];
    logic [1:0] frame_count;
    logic       history_full;

    assign history_full = (frame_count == 2'd2);

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_count  <= '0;
            window_valid <= 1'b0;
        end else begin
            window_valid <= in_valid && history_full;
            if (in_valid && !history_full) begin
                frame_count <= frame_count + 2'd1;
            end
        end
    end

    // Two-frame history.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            hist_flags[1] <= hist_flags[0];
            hist_ener[1]  <= hist_ener[0];
            hist_flags[0] <= in_flags;
            hist_ener[0]  <= in_ener;
        end
    end

    // Oldest tail, middle frame, newest frame.
    always_ff @(posedge clk) begin
        if (in_valid && history_full) begin
            for (int i = 0; i < tail_len; i++) begin
                window_flags[i] <= hist_flags[1][`SUBFRAME_WIDTH + i];
                window_ener[i]  <= hist_ener[1][`SUBFRAME_WIDTH + i];
            end
            for (int i = 0; i < `WIDTH; i++) begin
                window_flags[tail_len + i]          <= hist_flags[0][i];
                window_ener[tail_len + i]           <= hist_ener[0][i];
                window_flags[tail_len + `WIDTH + i] <= in_flags[i];
                window_ener[tail_len + `WIDTH + i]  <= in_ener[i];
            end
        end
    end

    // Count saturates at two held frames.
    assert property (@(posedge clk) disable iff (reset) frame_count <= 2'd2);

endmodule

`default_nettype wire

// File: lowest_energy_flag_locator.sv
`include "symbol_adjust_cfg.svh"
`default_nettype none

module lowest_energy_flag_locator (
    input  wire symbol_adjust_pkg::flag_t flags [`WIDTH],
    input  wire symbol_adjust_pkg::ener_t flag_ener [`WIDTH],
    output symbol_adjust_pkg::flag_t      best_flag [`WIDTH]
);

    // Neighbourhood reach on either side.
    localparam int reach = `PATTERN_DEPTH - 1;

    logic [`WIDTH-1:0] flagged;
    logic [`WIDTH-1:0] beaten;

    always_comb begin
        for (int i = 0; i < `WIDTH; i++) begin
            flagged[i] = (flags[i] != '0);
        end
    end

    // Lower energy wins, ties go to the lower index.
    always_comb begin
        for (int i = 0; i < `WIDTH; i++) begin
            beaten[i] = 1'b0;
            for (int j = 0; j < `WIDTH; j++) begin
                if (j != i && j >= i - reach && j <= i + reach && flagged[j]) begin
                    if (flag_ener[j] < flag_ener[i]) begin
                        beaten[i] = 1'b1;
                    end
                    if (flag_ener[j] == flag_ener[i] && j < i) begin
                        beaten[i] = 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `WIDTH; i++) begin
            if (flagged[i] && !beaten[i]) begin
                best_flag[i] = flags[i];
            end else begin
                best_flag[i] = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: trellis_pattern_table.sv
`include "symbol_adjust_cfg.svh"
`default_nettype none

module trellis_pattern_table (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 pattern_write,
    input  wire symbol_adjust_pkg::pattern_idx_t pattern_index,
    input  wire symbol_adjust_pkg::branch_t     pattern_taps [`PATTERN_DEPTH],
    output symbol_adjust_pkg::adjust_t          unfolded [`NUM_FLAGS][`PATTERN_DEPTH]
);
    import symbol_adjust_pkg::*;

    branch_t patterns [`NUM_PATTERNS][`PATTERN_DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_PATTERNS; i++) begin
                for (int j = 0; j < `PATTERN_DEPTH; j++) begin
                    patterns[i][j] <= '0;
                end
            end
        end else if (pattern_write) begin
            patterns[pattern_index] <= pattern_taps;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Unfolded view indexed directly by flag code.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int j = 0; j < `PATTERN_DEPTH; j++) begin
            unfolded[0][j] = '0;
        end
        for (int i = 0; i < `NUM_PATTERNS; i++) begin
            for (int j = 0; j < `PATTERN_DEPTH; j++) begin
                // Sign extend, then negate for the even codes.
                unfolded[2*i+1][j] = adjust_t'(patterns[i][j]);
                unfolded[2*i+2][j] = -adjust_t'(patterns[i][j]);
            end
        end
    end

endmodule

`default_nettype wire

// File: symbol_adjust_combiner.sv
`include "symbol_adjust_cfg.svh"
`default_nettype none

module symbol_adjust_combiner (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             window_valid,
    input  wire symbol_adjust_pkg::flag_t   blk_best [2][`WIDTH],
    input  wire symbol_adjust_pkg::flag_t   red_best [2][`WIDTH],
    input  wire symbol_adjust_pkg::adjust_t unfolded [`NUM_FLAGS][`PATTERN_DEPTH],
    output logic                            adjust_valid,
    output symbol_adjust_pkg::adjust_t      symbol_adjust [`WIDTH]
);
    import symbol_adjust_pkg::*;

    localparam int row_len   = 2 * `WIDTH;
    localparam int blk_tail  = `WIDTH - `SUBFRAME_WIDTH;
    localparam int first_pos = `SUBFRAME_WIDTH - `PATTERN_DEPTH;
    localparam int last_pos  = `WIDTH + `SUBFRAME_WIDTH - 1;

    flag_t   red_row [row_len];
    flag_t   blk_row [row_len];
    flag_t   selected [row_len];
    adjust_t row_adjust [row_len];
    logic    flags_in_range;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Align both groupings on one row.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int i = 0; i < row_len; i++) begin
            blk_row[i] = '0;
        end
        for (int i = 0; i < blk_tail; i++) begin
            blk_row[i] = blk_best[0][`SUBFRAME_WIDTH + i];
        end
        for (int i = 0; i < `WIDTH; i++) begin
            blk_row[blk_tail + i] = blk_best[1][i];
            red_row[i]            = red_best[0][i];
            red_row[`WIDTH + i]   = red_best[1][i];
        end
    end

    // Agreement, then pattern accumulation.
    always_comb begin
        for (int i = 0; i < row_len; i++) begin
            selected[i]   = '0;
            row_adjust[i] = '0;
        end
        for (int p = first_pos; p <= last_pos; p++) begin
            if (red_row[p] == blk_row[p]) begin
                selected[p] = blk_row[p];
            end
            for (int j = 0; j < `PATTERN_DEPTH; j++) begin
                row_adjust[p + j] = row_adjust[p + j] + unfolded[selected[p]][j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            adjust_valid <= 1'b0;
            for (int i = 0; i < `WIDTH; i++) begin
                symbol_adjust[i] <= '0;
            end
        end else begin
            adjust_valid <= window_valid;
            if (window_valid) begin
                for (int i = 0; i < `WIDTH; i++) begin
                    symbol_adjust[i] <= row_adjust[`SUBFRAME_WIDTH + i];
                end
            end
        end
    end

    // Locator outputs must be legal flag codes.
    always_comb begin
        flags_in_range = 1'b1;
        for (int k = 0; k < 2; k++) begin
            for (int i = 0; i < `WIDTH; i++) begin
                if (blk_best[k][i] >= `NUM_FLAGS || red_best[k][i] >= `NUM_FLAGS) begin
                    flags_in_range = 1'b0;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        adjust_valid |-> $past(window_valid));

    assert property (@(posedge clk) disable iff (reset)
        window_valid |-> flags_in_range);

endmodule

`default_nettype wire

// File: symbol_adjust_top.sv
`include "symbol_adjust_cfg.svh"
`default_nettype none

module symbol_adjust_top (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 in_valid,
    input  wire symbol_adjust_pkg::flag_t       in_flags [`WIDTH],
    input  wire symbol_adjust_pkg::ener_t       in_ener [`WIDTH],
    input  wire                                 pattern_write,
    input  wire symbol_adjust_pkg::pattern_idx_t pattern_index,
    input  wire symbol_adjust_pkg::branch_t     pattern_taps [`PATTERN_DEPTH],
    output logic                                adjust_valid,
    output symbol_adjust_pkg::adjust_t          symbol_adjust [`WIDTH]
);
    import symbol_adjust_pkg::*;

    // Block slices first, then the redundant ones.
    localparam int slice_start [4] = '{
        0,
        `WIDTH,
        `WIDTH - `SUBFRAME_WIDTH,
        2 * `WIDTH - `SUBFRAME_WIDTH
    };

    logic         window_valid;
    flag_t        window_flags [`WINDOW_LEN];
    ener_t        window_ener [`WINDOW_LEN];
    wire flag_t   slice_best [4][`WIDTH];
    flag_t        blk_best [2][`WIDTH];
    flag_t        red_best [2][`WIDTH];
    adjust_t      unfolded [`NUM_FLAGS][`PATTERN_DEPTH];

    flag_window_buffer i_window_buffer (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_flags     (in_flags),
        .in_ener      (in_ener),
        .window_valid (window_valid),
        .window_flags (window_flags),
        .window_ener  (window_ener)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Locators over fixed window slices.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar g = 0; g < 4; g++) begin : g_locator
        flag_t slice_flags [`WIDTH];
        ener_t slice_ener [`WIDTH];

        always_comb begin
            for (int i = 0; i < `WIDTH; i++) begin
                slice_flags[i] = window_flags[slice_start[g] + i];
                slice_ener[i]  = window_ener[slice_start[g] + i];
            end
        end

        lowest_energy_flag_locator i_locator (
            .flags     (slice_flags),
            .flag_ener (slice_ener),
            .best_flag (slice_best[g])
        );
    end

    always_comb begin
        blk_best[0] = slice_best[0];
        blk_best[1] = slice_best[1];
        red_best[0] = slice_best[2];
        red_best[1] = slice_best[3];
    end

    trellis_pattern_table i_pattern_table (
        .clk           (clk),
        .reset         (reset),
        .pattern_write (pattern_write),
        .pattern_index (pattern_index),
        .pattern_taps  (pattern_taps),
        .unfolded      (unfolded)
    );

    symbol_adjust_combiner i_combiner (
        .clk           (clk),
        .reset         (reset),
        .window_valid  (window_valid),
        .blk_best      (blk_best),
        .red_best      (red_best),
        .unfolded      (unfolded),
        .adjust_valid  (adjust_valid),
        .symbol_adjust (symbol_adjust)
    );

endmodule

`default_nettype wire

// File: tb_symbol_adjust.sv
`include "symbol_adjust_cfg.svh"
`default_nettype none

module tb_symbol_adjust;
    timeunit 1ns;
    timeprecision 1ps;
    import symbol_adjust_pkg::*;

    localparam int reset_cycles  = 8;
    localparam int n_sparse      = 40;
    localparam int n_dense       = 60;
    localparam int n_band        = 40;
    localparam int n_spacing     = 60;
    localparam int n_writes      = 12;
    localparam int stim_cycles   = reset_cycles + 2 * n_sparse + 2 * n_dense + n_band
                                   + 4 * n_spacing + 2 * n_writes + 20;
    localparam int timeout_limit = 2 * stim_cycles + 100;

    logic         clk;
    logic         reset;
    logic         in_valid;
    flag_t        in_flags [`WIDTH];
    ener_t        in_ener [`WIDTH];
    logic         pattern_write;
    pattern_idx_t pattern_index;
    branch_t      pattern_taps [`PATTERN_DEPTH];
    logic         adjust_valid;
    adjust_t      symbol_adjust [`WIDTH];

    // Model state.
    int                  model_taps [`NUM_PATTERNS][`PATTERN_DEPTH];
    int                  hist_flags [2][`WIDTH];
    int                  hist_ener [2][`WIDTH];
    int                  hist_count;
    int                  win_flags [`WINDOW_LEN];
    int                  win_ener [`WINDOW_LEN];
    logic [3*`WIDTH-1:0] exp_q [$];
    int                  strobe_q [$];
    logic [3*`WIDTH-1:0] exp_frame;
    int                  exp_strobe;
    int                  cycle = 0;
    int                  errors = 0;

    symbol_adjust_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_flags      (in_flags),
        .in_ener       (in_ener),
        .pattern_write (pattern_write),
        .pattern_index (pattern_index),
        .pattern_taps  (pattern_taps),
        .adjust_valid  (adjust_valid),
        .symbol_adjust (symbol_adjust)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycle);
            $display("Errors: %0d", errors);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            errors++;
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Flag surviving at slice position i, or 0.
    function automatic int kept_flag(input int start, input int i);
        int f;
        int e;
        f = win_flags[start + i];
        e = win_ener[start + i];
        if (f == 0) return 0;
        for (int j = 0; j < `WIDTH; j++) begin
            if (j != i && j >= i - (`PATTERN_DEPTH - 1) && j <= i + (`PATTERN_DEPTH - 1)
                && win_flags[start + j] != 0) begin
                if (win_ener[start + j] < e || (win_ener[start + j] == e && j < i)) return 0;
            end
        end
        return f;
    endfunction

    function automatic int tap_value(input int f, input int j);
        int t;
        t = model_taps[(f - 1) / 2][j];
        if (f % 2 == 0) t = -t;
        return t;
    endfunction

    task automatic push_expected();
        int                  blk_row [2*`WIDTH];
        int                  red_row [2*`WIDTH];
        int                  acc [2*`WIDTH];
        int                  sel;
        logic [3*`WIDTH-1:0] frame;
        for (int i = 0; i < 2 * `WIDTH; i++) begin
            blk_row[i] = 0;
            acc[i]     = 0;
        end
        for (int i = 0; i < `WIDTH - `SUBFRAME_WIDTH; i++) begin
            blk_row[i] = kept_flag(0, `SUBFRAME_WIDTH + i);
        end
        for (int i = 0; i < `WIDTH; i++) begin
            blk_row[`WIDTH - `SUBFRAME_WIDTH + i] = kept_flag(`WIDTH, i);
            red_row[i]          = kept_flag(`WIDTH - `SUBFRAME_WIDTH, i);
            red_row[`WIDTH + i] = kept_flag(2 * `WIDTH - `SUBFRAME_WIDTH, i);
        end
        for (int p = `SUBFRAME_WIDTH - `PATTERN_DEPTH; p < `WIDTH + `SUBFRAME_WIDTH; p++) begin
            sel = (red_row[p] == blk_row[p]) ? blk_row[p] : 0;
            if (sel != 0) begin
                for (int j = 0; j < `PATTERN_DEPTH; j++) acc[p + j] += tap_value(sel, j);
            end
        end
        for (int i = 0; i < `WIDTH; i++) frame[3*i +: 3] = acc[`SUBFRAME_WIDTH + i][2:0];
        exp_q.push_back(frame);
        strobe_q.push_back(cycle);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Mode 0 single flag, 1 dense with ties, 2 clustered near slice edges.
    task automatic send_frame(input int mode, input int gap);
        int pos;
        for (int i = 0; i < `WIDTH; i++) begin
            in_flags[i] = '0;
            in_ener[i]  = ener_t'($urandom_range(1023));
        end
        if (mode == 0) begin
            pos = $urandom_range(`WIDTH - 1);
            in_flags[pos] = flag_t'($urandom_range(`NUM_FLAGS - 1, 1));
        end else begin
            for (int i = 0; i < `WIDTH; i++) begin
                pos = i % `SUBFRAME_WIDTH;
                if ((mode == 1 && $urandom_range(1) == 1) ||
                    (mode == 2 && (pos <= 1 || pos >= 6) && $urandom_range(2) != 0)) begin
                    in_flags[i] = flag_t'($urandom_range(`NUM_FLAGS - 1, 1));
                    in_ener[i]  = ener_t'($urandom_range(7));
                end
            end
        end
        if (hist_count == 2) begin
            for (int i = 0; i < `WIDTH - `SUBFRAME_WIDTH; i++) begin
                win_flags[i] = hist_flags[1][`SUBFRAME_WIDTH + i];
                win_ener[i]  = hist_ener[1][`SUBFRAME_WIDTH + i];
            end
            for (int i = 0; i < `WIDTH; i++) begin
                win_flags[`SUBFRAME_WIDTH + i]          = hist_flags[0][i];
                win_ener[`SUBFRAME_WIDTH + i]           = hist_ener[0][i];
                win_flags[`SUBFRAME_WIDTH + `WIDTH + i] = in_flags[i];
                win_ener[`SUBFRAME_WIDTH + `WIDTH + i]  = in_ener[i];
            end
            push_expected();
        end
        for (int i = 0; i < `WIDTH; i++) begin
            hist_flags[1][i] = hist_flags[0][i];
            hist_ener[1][i]  = hist_ener[0][i];
            hist_flags[0][i] = in_flags[i];
            hist_ener[0][i]  = in_ener[i];
        end
        if (hist_count < 2) hist_count++;
        in_valid = 1'b1;
        step();
        in_valid = 1'b0;
        repeat (gap) step();
    endtask

    task automatic write_pattern(input int idx);
        pattern_index = pattern_idx_t'(idx);
        for (int j = 0; j < `PATTERN_DEPTH; j++) begin
            model_taps[idx][j] = int'($urandom_range(3)) - 2;
            pattern_taps[j]    = branch_t'(model_taps[idx][j]);
        end
        pattern_write = 1'b1;
        step();
        pattern_write = 1'b0;
    endtask

    always @(negedge clk) begin
        if (!reset && adjust_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected output: adjust_valid high at %0t with no frame pending",
                         $time);
            end else begin
                exp_frame  = exp_q.pop_front();
                exp_strobe = strobe_q.pop_front();
                check_value("adjust_valid latency", cycle - exp_strobe, 2);
                for (int i = 0; i < `WIDTH; i++) begin
                    check_value($sformatf("symbol_adjust[%0d]", i), symbol_adjust[i],
                                adjust_t'(exp_frame[3*i +: 3]));
                end
            end
        end
    end

    initial begin
        int k;
        void'($urandom(71501));
        reset         = 1'b1;
        in_valid      = 1'b0;
        pattern_write = 1'b0;
        pattern_index = '0;
        hist_count    = 0;
        for (int i = 0; i < `WIDTH; i++) begin
            in_flags[i] = '0;
            in_ener[i]  = '0;
        end
        for (int j = 0; j < `PATTERN_DEPTH; j++) pattern_taps[j] = '0;
        for (int i = 0; i < `NUM_PATTERNS; i++) begin
            for (int j = 0; j < `PATTERN_DEPTH; j++) model_taps[i][j] = 0;
        end
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;
        check_value("adjust_valid", adjust_valid, 0);
        for (int i = 0; i < `WIDTH; i++) begin
            check_value($sformatf("symbol_adjust[%0d]", i), symbol_adjust[i], 0);
        end

        for (k = 0; k < `NUM_PATTERNS; k++) write_pattern(k);
        for (k = 0; k < n_sparse; k++) send_frame(0, $urandom_range(1));
        for (k = 0; k < n_dense; k++) send_frame(1, 0);
        for (k = 0; k < n_band; k++) send_frame(2, 0);
        // Mixed gaps with table rewrites between frames.
        for (k = 0; k < n_spacing; k++) begin
            if (k % 10 == 5) write_pattern($urandom_range(`NUM_PATTERNS - 1));
            send_frame($urandom_range(2), $urandom_range(3));
        end

        for (k = 0; k < 8 && exp_q.size() > 0; k++) step();
        repeat (4) step();
        if (exp_q.size() != 0) begin
            errors += exp_q.size();
            $display("Missing output: %0d frames never produced adjust_valid", exp_q.size());
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
symbol_adjust_pkg.sv
flag_window_buffer.sv
lowest_energy_flag_locator.sv
trellis_pattern_table.sv
symbol_adjust_combiner.sv
symbol_adjust_top.sv
tb_symbol_adjust.sv

// File: Bender.yml
package:
  name: symbol_adjust

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - symbol_adjust_pkg.sv
      - flag_window_buffer.sv
      - lowest_energy_flag_locator.sv
      - trellis_pattern_table.sv
      - symbol_adjust_combiner.sv
      - symbol_adjust_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_symbol_adjust.sv
